// ==== Makefile ====
TOP = tb_fetch_unit

sim:
	verilator --binary --assert --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== logic/btac.sv ====
`default_nettype none
`timescale 1ns/10ps

module btac import fetch_pkg::*; #(
  parameter int BTAC_ENTRIES = 16  // Power of two, at least 2
) (
  input  wire logic         clock,
  input  wire logic         reset,
  input  wire logic [31:0]  lookup_pc,
  input  wire btac_update_t update,
  output btac_out_t         btac_out
);

  localparam int IDX_BITS = $clog2(BTAC_ENTRIES);
  localparam int TAG_BITS = 32 - 3 - IDX_BITS;

  logic [BTAC_ENTRIES-1:0] valid_q;
  logic [TAG_BITS-1:0]     tag_q    [BTAC_ENTRIES];
  logic [31:0]             target_q [BTAC_ENTRIES];

  logic [IDX_BITS-1:0]     rd_idx;
  logic [TAG_BITS-1:0]     rd_tag;
  logic [IDX_BITS-1:0]     wr_idx;
  logic [TAG_BITS-1:0]     wr_tag;
  logic                    rd_hit;
  logic                    wr_match;

  // Pairs are 8 bytes, so the index starts at bit 3
  assign rd_idx = lookup_pc[IDX_BITS+2:3];
  assign rd_tag = lookup_pc[31:IDX_BITS+3];
  assign wr_idx = update.pc[IDX_BITS+2:3];
  assign wr_tag = update.pc[31:IDX_BITS+3];

  assign rd_hit   = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

  assign btac_out = '{
    hit:    rd_hit,
    target: target_q[rd_idx],
    pc:     lookup_pc
  };

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= '0;
    end else if (update.valid) begin
      if (update.taken) begin
        valid_q[wr_idx] <= 1'b1;
      end else if (wr_match) begin
        // Not taken any more, forget it
        valid_q[wr_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (update.valid && update.taken) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= update.target;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // Widest double-word address the load port can carry
  localparam int IMEM_ADDR_MAX = 12;

  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    ctrl = 2'd2   // One cycle of quiet after an aborted access
  } fetch_state_e;

  typedef enum logic [1:0] {
    trap       = 2'd0,
    mret       = 2'd1,
    mispredict = 2'd2
  } redirect_kind_e;

  typedef struct packed {
    logic           valid;
    redirect_kind_e kind;
    logic [31:0]    target;
  } redirect_t;

  // Branch resolution from the back end
  typedef struct packed {
    logic        valid;
    logic        taken;
    logic [31:0] pc;
    logic [31:0] target;
  } btac_update_t;

  typedef struct packed {
    logic        hit;
    logic [31:0] target;  // Predicted next fetch address
    logic [31:0] pc;      // Address of the predicted branch
  } btac_out_t;

  typedef struct packed {
    logic        valid;
    logic        spec;    // Kills every response still in flight
    logic [31:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic        ready;
    logic [63:0] rdata;
  } imem_rsp_t;

  // One instruction pair on its way to decode
  typedef struct packed {
    logic [31:0] pc;
    logic [63:0] rdata;
    logic        taken;
    logic [31:0] tpc;
  } fetch_packet_t;

  typedef struct packed {
    logic                     valid;
    logic [IMEM_ADDR_MAX-1:0] addr;  // Double-word index
    logic [63:0]              data;
  } mem_load_t;

endpackage

`default_nettype wire

// ==== logic/fetch_queue.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_queue import fetch_pkg::*; #(
  parameter int QUEUE_DEPTH  = 8,
  parameter int CREDITS      = 4,
  parameter int IMEM_LATENCY = 2
) (
  input  wire logic          clock,
  input  wire logic          reset,
  input  wire logic          push,
  input  wire fetch_packet_t push_packet,
  input  wire logic          flush,
  output logic               almost_full,
  output logic               out_valid,
  output fetch_packet_t      out_packet,
  input  wire logic          credit_return
);

  localparam int PTR_BITS    = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_BITS    = PTR_BITS + 1;
  localparam int CREDIT_BITS = $clog2(CREDITS + 1);

  fetch_packet_t          fifo_mem [QUEUE_DEPTH];
  logic [PTR_BITS-1:0]    rd_ptr;
  logic [PTR_BITS-1:0]    wr_ptr;
  logic [CNT_BITS-1:0]    count;
  logic [CREDIT_BITS-1:0] credits;
  logic                   pop;
  logic                   do_push;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Reserve a slot for every request that may still be in flight
  assign almost_full = (int'(count) + IMEM_LATENCY + 1) > QUEUE_DEPTH;
  assign out_valid   = (count != '0) && (credits != '0);
  assign out_packet  = fifo_mem[rd_ptr];
  assign pop         = out_valid;
  assign do_push     = push && !flush;

  always_ff @(posedge clock) begin
    if (!reset) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count   <= '0;
      credits <= CREDIT_BITS'(CREDITS);
    end else begin
      credits <= credits - CREDIT_BITS'(pop) + CREDIT_BITS'(credit_return);
      if (flush) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
      end else begin
        if (do_push) wr_ptr <= next_ptr(wr_ptr);
        if (pop) rd_ptr <= next_ptr(rd_ptr);
        count <= count + CNT_BITS'(do_push) - CNT_BITS'(pop);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      fifo_mem[wr_ptr] <= push_packet;
    end
  end

  // Decode never returns more than it was given
  credit_bound: assert property (
    @(posedge clock) disable iff (!reset)
      int'(credits) <= CREDITS
  );

endmodule

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_stage import fetch_pkg::*; #(
  parameter logic [31:0] RESET_PC     = 32'h0000_0000,
  parameter int          IMEM_LATENCY = 2
) (
  input  wire logic          clock,
  input  wire logic          reset,
  input  wire redirect_t     redirect,
  input  wire btac_out_t     btac_out,
  output logic [31:0]        lookup_pc,
  output imem_req_t          imem_req,
  input  wire imem_rsp_t     imem_rsp,
  input  wire logic          almost_full,
  output logic               push,
  output fetch_packet_t      push_packet,
  output logic               flushing
);

  // What travels alongside a request until its data comes back
  typedef struct packed {
    logic [31:0] pc;
    logic        taken;
    logic [31:0] tpc;
  } fetch_tag_t;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic [31:0]  pc_q;
  logic [31:0]  pc_d;
  logic [31:0]  issue_pc;
  logic         req_valid;
  fetch_tag_t   tag_q [IMEM_LATENCY];

  always_comb begin
    issue_pc  = redirect.valid ? redirect.target : pc_q;
    req_valid = 1'b0;
    state_d   = state_q;

    if (redirect.valid) begin
      // Back end wins over everything, request goes out this cycle
      req_valid = 1'b1;
      state_d   = ctrl;
    end else begin
      case (state_q)
        idle: begin
          state_d = busy;
        end
        busy: begin
          req_valid = !almost_full;  // Hold pc while the queue has no room
        end
        ctrl: begin
          state_d = busy;
        end
        default: begin
          state_d = idle;
        end
      endcase
    end

    pc_d = pc_q;
    if (req_valid) begin
      if (btac_out.hit) begin
        pc_d = btac_out.target;
      end else begin
        pc_d = issue_pc + 32'd8;
      end
    end
  end

  assign lookup_pc = issue_pc;
  assign flushing  = redirect.valid;

  assign imem_req = '{
    valid: req_valid,
    spec:  redirect.valid,
    addr:  issue_pc
  };

  // Old-stream data arriving during a redirect is dropped
  assign push = imem_rsp.ready && !redirect.valid;

  assign push_packet = '{
    pc:    tag_q[IMEM_LATENCY-1].pc,
    rdata: imem_rsp.rdata,
    taken: tag_q[IMEM_LATENCY-1].taken,
    tpc:   tag_q[IMEM_LATENCY-1].tpc
  };

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= idle;
      pc_q    <= RESET_PC;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  // Shifts in step with the memory pipeline
  always_ff @(posedge clock) begin
    tag_q[0] <= '{
      pc:    issue_pc,
      taken: btac_out.hit,
      tpc:   btac_out.hit ? btac_out.pc : 32'h0
    };
    for (int i = 1; i < IMEM_LATENCY; i++) begin
      tag_q[i] <= tag_q[i-1];
    end
  end

  // Every pushed pair was requested with room in the queue, or after a flush
  push_had_room: assert property (
    @(posedge clock) disable iff (!reset)
      push |-> $past(imem_req.valid && (imem_req.spec || !almost_full), IMEM_LATENCY)
  );

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_unit import fetch_pkg::*; #(
  parameter logic [31:0] RESET_PC     = 32'h0000_0000,
  parameter int          BTAC_ENTRIES = 16,
  parameter int          IMEM_LATENCY = 2,
  parameter int          ADDR_BITS    = 10,
  parameter int          QUEUE_DEPTH  = 8,
  parameter int          CREDITS      = 4
) (
  input  wire logic          clock,
  input  wire logic          reset,
  input  wire redirect_t     redirect,
  input  wire btac_update_t  btac_update,
  input  wire mem_load_t     mem_load,
  output logic               out_valid,
  output fetch_packet_t      out_packet,
  input  wire logic          credit_return
);

  logic [31:0]   lookup_pc;
  btac_out_t     btac_out;
  imem_req_t     imem_req;
  imem_rsp_t     imem_rsp;
  logic          almost_full;
  logic          push;
  logic          flushing;
  fetch_packet_t push_packet;

  if (ADDR_BITS > IMEM_ADDR_MAX) begin : g_addr_check
    $error("ADDR_BITS exceeds the load port width");
  end

  if (QUEUE_DEPTH <= IMEM_LATENCY + 1) begin : g_depth_check
    $error("Queue too shallow to cover the memory latency");
  end

  fetch_stage #(
    .RESET_PC     (RESET_PC),
    .IMEM_LATENCY (IMEM_LATENCY)
  ) u_fetch_stage (
    .clock        (clock),
    .reset        (reset),
    .redirect     (redirect),
    .btac_out     (btac_out),
    .lookup_pc    (lookup_pc),
    .imem_req     (imem_req),
    .imem_rsp     (imem_rsp),
    .almost_full  (almost_full),
    .push         (push),
    .push_packet  (push_packet),
    .flushing     (flushing)
  );

  btac #(
    .BTAC_ENTRIES (BTAC_ENTRIES)
  ) u_btac (
    .clock        (clock),
    .reset        (reset),
    .lookup_pc    (lookup_pc),
    .update       (btac_update),
    .btac_out     (btac_out)
  );

  itim #(
    .IMEM_LATENCY (IMEM_LATENCY),
    .ADDR_BITS    (ADDR_BITS)
  ) u_itim (
    .clock        (clock),
    .reset        (reset),
    .load         (mem_load),
    .req          (imem_req),
    .rsp          (imem_rsp)
  );

  fetch_queue #(
    .QUEUE_DEPTH  (QUEUE_DEPTH),
    .CREDITS      (CREDITS),
    .IMEM_LATENCY (IMEM_LATENCY)
  ) u_fetch_queue (
    .clock         (clock),
    .reset         (reset),
    .push          (push),
    .push_packet   (push_packet),
    .flush         (flushing),
    .almost_full   (almost_full),
    .out_valid     (out_valid),
    .out_packet    (out_packet),
    .credit_return (credit_return)
  );

endmodule

`default_nettype wire

// ==== logic/itim.sv ====
`default_nettype none
`timescale 1ns/10ps

module itim import fetch_pkg::*; #(
  parameter int IMEM_LATENCY = 2,
  parameter int ADDR_BITS    = 10
) (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire mem_load_t load,
  input  wire imem_req_t req,
  output imem_rsp_t      rsp
);

  logic [63:0]             ram [2**ADDR_BITS];
  logic [ADDR_BITS-1:0]    rd_addr;
  logic [IMEM_LATENCY-1:0] valid_q;
  logic [63:0]             data_q [IMEM_LATENCY];

  assign rd_addr = req.addr[ADDR_BITS+2:3];  // Byte address to double word

  assign rsp = '{
    ready: valid_q[IMEM_LATENCY-1],
    rdata: data_q[IMEM_LATENCY-1]
  };

  // Preload before the run
  always_ff @(posedge clock) begin
    if (load.valid) begin
      ram[load.addr[ADDR_BITS-1:0]] <= load.data;
    end
  end

  always_ff @(posedge clock) begin
    data_q[0] <= ram[rd_addr];
    for (int i = 1; i < IMEM_LATENCY; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= req.valid;
      for (int i = 1; i < IMEM_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1] && !req.spec;  // Abort drops older reads
      end
    end
  end

  // Loading happens only while fetch is quiet
  no_load_during_fetch: assert property (
    @(posedge clock) disable iff (!reset)
      !(load.valid && req.valid)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
logic/fetch_pkg.sv
logic/fetch_stage.sv
logic/btac.sv
logic/itim.sv
logic/fetch_queue.sv
logic/fetch_unit.sv
tb/fetch_checker.sv
tb/tb_fetch_unit.sv

// ==== tb/fetch_checker.sv ====
`default_nettype none
`timescale 1ns/10ps

module fetch_checker import fetch_pkg::*; #(
  parameter logic [31:0] RESET_PC     = 32'h0000_0000,
  parameter int          BTAC_ENTRIES = 16,
  parameter int          ADDR_BITS    = 10,
  parameter int          CREDITS      = 4
) (
  input  wire logic          clock,
  input  wire logic          reset,
  input  wire redirect_t     redirect,
  input  wire btac_update_t  btac_update,
  input  wire mem_load_t     mem_load,
  input  wire logic          out_valid,
  input  wire fetch_packet_t out_packet,
  input  wire logic          credit_return,
  input  wire logic [7:0]    test_num,
  output int                 error_count,
  output int                 packet_count
);

  localparam int MEM_WORDS = 2 ** ADDR_BITS;
  localparam int IDX_BITS  = $clog2(BTAC_ENTRIES);

  logic [63:0] mem_model [MEM_WORDS];
  bit          bt_valid  [BTAC_ENTRIES];
  logic [31:0] bt_tag    [BTAC_ENTRIES];
  logic [31:0] bt_target [BTAC_ENTRIES];

  logic [31:0] exp_pc = RESET_PC;  // Pc of the next pair decode should see
  logic [7:0]  cur_test = 8'd0;
  int          errors = 0;
  int          packets = 0;
  int          test_errors = 0;
  int          test_packets = 0;
  int          sent = 0;
  int          returned = 0;

  assign error_count  = errors;
  assign packet_count = packets;

  function automatic int btac_index(input logic [31:0] pc);
    return int'((pc >> 3) % BTAC_ENTRIES);
  endfunction

  function automatic logic btac_hit(input logic [31:0] pc);
    int idx;
    idx = btac_index(pc);
    return bt_valid[idx] && (bt_tag[idx] == (pc >> (IDX_BITS + 3)));
  endfunction

  // Pair the front end owes decode when the stream is at pc
  function automatic fetch_packet_t expected_packet(input logic [31:0] pc);
    fetch_packet_t pkt;
    pkt.pc    = pc;
    pkt.rdata = mem_model[int'((pc >> 3) % MEM_WORDS)];
    pkt.taken = btac_hit(pc);
    pkt.tpc   = pkt.taken ? pc : 32'h0;
    return pkt;
  endfunction

  function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc);
    return btac_hit(pc) ? bt_target[btac_index(pc)] : pc + 32'd8;
  endfunction

  task automatic train_model(input btac_update_t upd);
    int idx;
    idx = btac_index(upd.pc);
    if (upd.taken) begin
      bt_valid[idx]  = 1'b1;
      bt_tag[idx]    = upd.pc >> (IDX_BITS + 3);
      bt_target[idx] = upd.target;
    end else if (btac_hit(upd.pc)) begin
      bt_valid[idx] = 1'b0;
    end
  endtask

  task automatic check_field(input string name, input logic [63:0] want, input logic [63:0] got);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, want, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
    test_errors++;
  endtask

  always @(posedge clock) begin
    fetch_packet_t want;
    if (test_num != cur_test) begin
      if (cur_test != 8'd0) begin
        $display("test %0d finished: %0d packets checked, %0d errors",
                 cur_test, test_packets, test_errors);
      end
      cur_test     = test_num;
      test_packets = 0;
      test_errors  = 0;
    end
    if (mem_load.valid) begin
      mem_model[int'(mem_load.addr) % MEM_WORDS] = mem_load.data;
    end
    if (!reset) begin
      exp_pc   = RESET_PC;
      sent     = 0;
      returned = 0;
      for (int i = 0; i < BTAC_ENTRIES; i++) begin
        bt_valid[i] = 1'b0;
      end
      if (out_valid === 1'b1) report_failure("out_valid is high during reset");
    end else begin
      // A packet leaving in a redirect cycle still belongs to the old stream
      if (out_valid) begin
        want = expected_packet(exp_pc);
        check_field("out_packet.pc", 64'(want.pc), 64'(out_packet.pc));
        check_field("out_packet.rdata", want.rdata, out_packet.rdata);
        check_field("out_packet.taken", 64'(want.taken), 64'(out_packet.taken));
        check_field("out_packet.tpc", 64'(want.tpc), 64'(out_packet.tpc));
        exp_pc = next_fetch_pc(exp_pc);
        sent++;
        packets++;
        test_packets++;
        if (sent > returned + CREDITS) begin
          report_failure($sformatf("%0d packets sent with only %0d credits granted",
                                   sent, returned + CREDITS));
        end
      end
      if (credit_return) returned++;
      if (redirect.valid) exp_pc = redirect.target;
      if (btac_update.valid) train_model(btac_update);
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_fetch_unit.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_fetch_unit import fetch_pkg::*; ();

  localparam logic [31:0] RESET_PC      = 32'h0000_0100;
  localparam int          BTAC_ENTRIES  = 16;
  localparam int          IMEM_LATENCY  = 2;
  localparam int          ADDR_BITS     = 3;   // Small enough to fill during reset
  localparam int          QUEUE_DEPTH   = 8;
  localparam int          CREDITS       = 4;
  localparam int          RESET_CYCLES  = 10;
  localparam int          MEM_WORDS     = 2 ** ADDR_BITS;
  localparam logic [31:0] BRANCH_PC     = 32'h0000_0840;
  localparam logic [31:0] BRANCH_TARGET = 32'h0000_0940;  // Same index, other tag

  // Test lengths, in packets or cycles
  localparam int LEN_START    = 1;
  localparam int LEN_STREAM   = 20;
  localparam int LEN_REDIRECT = 8;
  localparam int LEN_BRANCH   = 8;
  localparam int HOLD_CYCLES  = 30;
  localparam int LEN_RESUME   = 16;
  localparam int TOTAL_LEN    = RESET_CYCLES + LEN_START + LEN_STREAM + 3 * LEN_REDIRECT
                              + 2 * LEN_BRANCH + HOLD_CYCLES + LEN_RESUME;
  localparam int WATCHDOG_CYCLES = TOTAL_LEN * (IMEM_LATENCY + 4);

  logic          clock = 1'b0;
  logic          reset;
  redirect_t     redirect;
  btac_update_t  btac_update;
  mem_load_t     mem_load;
  logic          credit_return = 1'b0;
  logic          out_valid;
  fetch_packet_t out_packet;
  logic          hold_credits;
  logic [7:0]    test_num;
  int            seed = 92;
  int            owed = 0;    // Packets decode has taken but not yet paid back
  int            error_count;
  int            packet_count;

  always #50 clock = ~clock;

  fetch_unit #(
    .RESET_PC     (RESET_PC),
    .BTAC_ENTRIES (BTAC_ENTRIES),
    .IMEM_LATENCY (IMEM_LATENCY),
    .ADDR_BITS    (ADDR_BITS),
    .QUEUE_DEPTH  (QUEUE_DEPTH),
    .CREDITS      (CREDITS)
  ) dut (
    .clock         (clock),
    .reset         (reset),
    .redirect      (redirect),
    .btac_update   (btac_update),
    .mem_load      (mem_load),
    .out_valid     (out_valid),
    .out_packet    (out_packet),
    .credit_return (credit_return)
  );

  fetch_checker #(
    .RESET_PC     (RESET_PC),
    .BTAC_ENTRIES (BTAC_ENTRIES),
    .ADDR_BITS    (ADDR_BITS),
    .CREDITS      (CREDITS)
  ) u_checker (
    .clock         (clock),
    .reset         (reset),
    .redirect      (redirect),
    .btac_update   (btac_update),
    .mem_load      (mem_load),
    .out_valid     (out_valid),
    .out_packet    (out_packet),
    .credit_return (credit_return),
    .test_num      (test_num),
    .error_count   (error_count),
    .packet_count  (packet_count)
  );

  // Decode model, pays each packet back after a random delay
  always @(posedge clock) begin
    int roll;
    if (!reset) begin
      owed = 0;
      credit_return <= 1'b0;
    end else begin
      if (out_valid) owed++;
      roll = $random(seed);
      if (owed > 0 && !hold_credits && roll[1:0] != 2'b00) begin
        credit_return <= 1'b1;
        owed--;
      end else begin
        credit_return <= 1'b0;
      end
    end
  end

  task automatic start_test(input logic [7:0] num);
    @(posedge clock);
    test_num <= num;
  endtask

  task automatic wait_packets(input int count);
    int seen;
    seen = 0;
    while (seen < count) begin
      @(posedge clock);
      if (out_valid) seen++;
    end
  endtask

  task automatic send_redirect(input redirect_kind_e redirect_kind, input logic [31:0] dest,
                               input btac_update_t update);
    @(posedge clock);
    redirect    <= '{valid: 1'b1, kind: redirect_kind, target: dest};
    btac_update <= update;
    @(posedge clock);
    redirect    <= '0;
    btac_update <= '0;
  endtask

  function automatic btac_update_t branch_update(input logic br_taken, input logic [31:0] br_pc,
                                                 input logic [31:0] br_target);
    return '{valid: 1'b1, taken: br_taken, pc: br_pc, target: br_target};
  endfunction

  initial begin
    reset        = 1'b0;
    redirect     = '0;
    btac_update  = '0;
    mem_load     = '0;
    hold_credits = 1'b0;
    test_num     = 8'd0;
    // Memory is filled while the front end sits in reset
    for (int i = 0; i < RESET_CYCLES - 1; i++) begin
      @(posedge clock);
      if (i < MEM_WORDS) begin
        mem_load <= '{valid: 1'b1, addr: IMEM_ADDR_MAX'(i), data: {$random(seed), $random(seed)}};
      end else begin
        mem_load <= '0;
      end
    end
    @(posedge clock);
    reset <= 1'b1;

    start_test(8'd1);
    wait_packets(LEN_START);

    start_test(8'd2);
    wait_packets(LEN_STREAM);

    // Targets lie far from the running stream so a leaked old pair shows up
    start_test(8'd3);
    send_redirect(trap, 32'h0000_0400, '0);
    wait_packets(LEN_REDIRECT);
    send_redirect(mret, 32'h0000_0600, '0);
    wait_packets(LEN_REDIRECT);
    send_redirect(mispredict, 32'h0000_0200, '0);
    wait_packets(LEN_REDIRECT);

    // Training rides on a mispredict that lands two pairs before the branch
    start_test(8'd4);
    send_redirect(mispredict, BRANCH_PC - 32'd16, branch_update(1'b1, BRANCH_PC, BRANCH_TARGET));
    wait_packets(LEN_BRANCH);
    send_redirect(mispredict, BRANCH_PC - 32'd16, branch_update(1'b0, BRANCH_PC, BRANCH_TARGET));
    wait_packets(LEN_BRANCH);

    start_test(8'd5);
    hold_credits <= 1'b1;
    repeat (HOLD_CYCLES) @(posedge clock);
    hold_credits <= 1'b0;
    wait_packets(LEN_RESUME);

    start_test(8'd0);
    repeat (2) @(negedge clock);
    $display("summary: 5 tests, %0d packets checked, %0d errors", packet_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
